// ==== build.f ====
+incdir+design
design/gb_mem_pkg.sv
design/mem_bus_if.sv
design/gb_mem_decoder.sv
design/gb_ram_bank.sv
design/gb_io_regs.sv
design/gb_memory_unit.sv
tb/gb_memory_unit_chk.sv
tb/gb_memory_unit_tb.sv

// ==== design/gb_io_regs.sv ====
// Holds timer, LCD, serial and DMA registers only; none of those engines run here
`include "gb_mem_cfg.svh"

module gb_io_regs (
	input logic clk,
	input logic rst,
	mem_bus_if.bank bus,
	input logic [3:0] joy_keys,
	input gb_mem_pkg::byte_t ly,
	input logic [1:0] stat_mode,
	input gb_mem_pkg::byte_t div,
	input gb_mem_pkg::irq_t irq_req,
	output logic div_reset,
	output gb_mem_pkg::byte_t lcdc,
	output gb_mem_pkg::byte_t scy,
	output gb_mem_pkg::byte_t scx,
	output gb_mem_pkg::byte_t tma,
	output gb_mem_pkg::byte_t tac,
	output gb_mem_pkg::irq_t irq_pending
);

	// CPU-written registers
	gb_mem_pkg::byte_t sb;
	gb_mem_pkg::byte_t sc;
	gb_mem_pkg::byte_t lyc;
	gb_mem_pkg::byte_t dma;
	gb_mem_pkg::byte_t bgp;
	gb_mem_pkg::byte_t obp0;
	gb_mem_pkg::byte_t obp1;
	gb_mem_pkg::byte_t wy;
	gb_mem_pkg::byte_t wx;
	gb_mem_pkg::byte_t ie;
	logic [2:0] tac_q;
	logic [1:0] p1_sel;
	logic [3:0] stat_bits;
	gb_mem_pkg::irq_t if_flags;
	gb_mem_pkg::irq_t if_next;

	// Peripheral inputs after one register stage
	logic [3:0] joy_q;
	gb_mem_pkg::byte_t ly_q;
	logic [1:0] mode_q;
	gb_mem_pkg::byte_t div_q;

	logic [7:0] reg_addr;
	logic wr_en;
	gb_mem_pkg::byte_t rd_byte;

	// Window offsets never exceed 0xFF
	assign reg_addr = bus.offset[7:0];
	assign wr_en = bus.cs & bus.we;

	// Requests win over a clearing write in the same cycle
	assign if_next = ((wr_en && reg_addr == 8'h0F) ? bus.wdata[4:0] : if_flags) | irq_req;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sb <= '0;
			sc <= '0;
			tma <= '0;
			tac_q <= '0;
			lcdc <= '0;
			scy <= '0;
			scx <= '0;
			lyc <= '0;
			dma <= '0;
			bgp <= '0;
			obp0 <= '0;
			obp1 <= '0;
			wy <= '0;
			wx <= '0;
			ie <= '0;
			p1_sel <= '0;
			stat_bits <= '0;
			if_flags <= '0;
			joy_q <= '0;
			ly_q <= '0;
			mode_q <= '0;
			div_q <= '0;
			div_reset <= 1'b0;
		end else begin
			joy_q <= joy_keys;
			ly_q <= ly;
			mode_q <= stat_mode;
			div_q <= div;
			if_flags <= if_next;
			// Any write to DIV asks the divider to restart
			div_reset <= wr_en && (reg_addr == 8'h04);
			if (wr_en) begin
				case (reg_addr)
					8'h00: p1_sel <= bus.wdata[5:4];
					8'h01: sb <= bus.wdata;
					8'h02: sc <= bus.wdata;
					8'h06: tma <= bus.wdata;
					8'h07: tac_q <= bus.wdata[2:0];
					8'h40: lcdc <= bus.wdata;
					8'h41: stat_bits <= bus.wdata[6:3];
					8'h42: scy <= bus.wdata;
					8'h43: scx <= bus.wdata;
					8'h45: lyc <= bus.wdata;
					8'h46: dma <= bus.wdata;
					8'h47: bgp <= bus.wdata;
					8'h48: obp0 <= bus.wdata;
					8'h49: obp1 <= bus.wdata;
					8'h4A: wy <= bus.wdata;
					8'h4B: wx <= bus.wdata;
					8'hFF: ie <= bus.wdata;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (reg_addr)
			8'h00: rd_byte = {2'b11, p1_sel, joy_q};
			8'h01: rd_byte = sb;
			8'h02: rd_byte = sc;
			8'h04: rd_byte = div_q;
			8'h06: rd_byte = tma;
			8'h07: rd_byte = {5'b0, tac_q};
			8'h0F: rd_byte = {3'b111, if_flags};
			8'h40: rd_byte = lcdc;
			// Coincidence flag is live, not latched
			8'h41: rd_byte = {1'b1, stat_bits, (ly_q == lyc), mode_q};
			8'h42: rd_byte = scy;
			8'h43: rd_byte = scx;
			8'h44: rd_byte = ly_q;
			8'h45: rd_byte = lyc;
			8'h46: rd_byte = dma;
			8'h47: rd_byte = bgp;
			8'h48: rd_byte = obp0;
			8'h49: rd_byte = obp1;
			8'h4A: rd_byte = wy;
			8'h4B: rd_byte = wx;
			8'hFF: rd_byte = ie;
			default: rd_byte = `GB_OPEN_BUS;
		endcase
	end

	always_ff @(posedge clk) begin
		if (bus.cs && !bus.we) begin
			bus.rdata <= rd_byte;
		end
	end

	assign tac = {5'b0, tac_q};
	assign irq_pending = ie[4:0] & if_flags;

endmodule

// ==== design/gb_mem_cfg.svh ====
// Address map of the on-chip regions only; cartridge ROM and echo RAM are not mapped here
`ifndef GB_MEM_CFG_SVH
`define GB_MEM_CFG_SVH

// Region base addresses, each region ends where the next compare begins
`define GB_VRAM_BASE   16'h8000
`define GB_WRAM0_BASE  16'hA000
`define GB_WRAM1_BASE  16'hC000

// OAM is 160 bytes used out of a 256 byte block
`define GB_OAM_BASE    16'hFE00
`define GB_OAM_END     16'hFEA0

// I/O register window, the IE register sits alone at the top of the map
`define GB_IO_BASE     16'hFF00
`define GB_IO_END      16'hFF4C
`define GB_HRAM_BASE   16'hFF80
`define GB_IE_ADDR     16'hFFFF

// Region depths in bytes, all powers of two
`define GB_VRAM_DEPTH  8192
`define GB_WRAM_DEPTH  8192
`define GB_OAM_DEPTH   256
`define GB_HRAM_DEPTH  128

// Returned for ROM space, echo RAM and unused holes
`define GB_OPEN_BUS    8'hFF

`endif

// ==== design/gb_mem_decoder.sv ====
// A read with wr also high is treated as a write and gives no rd_valid
`include "gb_mem_cfg.svh"

module gb_mem_decoder (
	input logic clk,
	input logic rst,
	input gb_mem_pkg::addr_t addr,
	input gb_mem_pkg::byte_t wdata,
	input logic rd,
	input logic wr,
	output gb_mem_pkg::byte_t rdata,
	output logic rd_valid,
	mem_bus_if.ctrl vram_bus,
	mem_bus_if.ctrl wram0_bus,
	mem_bus_if.ctrl wram1_bus,
	mem_bus_if.ctrl oam_bus,
	mem_bus_if.ctrl hram_bus,
	mem_bus_if.ctrl io_bus
);

	gb_mem_pkg::region_t region;
	gb_mem_pkg::region_t rd_region;
	gb_mem_pkg::addr_t base;
	gb_mem_pkg::addr_t rel_addr;
	logic access;
	logic rd_only;
	logic [12:0] offset;

	// Compare chain in ascending address order
	always_comb begin
		region = gb_mem_pkg::REGION_NONE;
		base = '0;
		if (addr < `GB_VRAM_BASE) begin
			// Cartridge ROM, not mapped
			region = gb_mem_pkg::REGION_NONE;
		end else if (addr < `GB_WRAM0_BASE) begin
			region = gb_mem_pkg::REGION_VRAM;
			base = `GB_VRAM_BASE;
		end else if (addr < `GB_WRAM1_BASE) begin
			region = gb_mem_pkg::REGION_WRAM0;
			base = `GB_WRAM0_BASE;
		end else if (addr < (`GB_WRAM1_BASE + `GB_WRAM_DEPTH)) begin
			region = gb_mem_pkg::REGION_WRAM1;
			base = `GB_WRAM1_BASE;
		end else if (addr >= `GB_OAM_BASE && addr < `GB_OAM_END) begin
			region = gb_mem_pkg::REGION_OAM;
			base = `GB_OAM_BASE;
		end else if ((addr >= `GB_IO_BASE && addr < `GB_IO_END) || addr == `GB_IE_ADDR) begin
			// IE lands at offset 0xFF of the window
			region = gb_mem_pkg::REGION_IO;
			base = `GB_IO_BASE;
		end else if (addr >= `GB_HRAM_BASE && addr < `GB_IE_ADDR) begin
			region = gb_mem_pkg::REGION_HRAM;
			base = `GB_HRAM_BASE;
		end
	end

	assign access = rd | wr;
	assign rd_only = rd & ~wr;
	assign rel_addr = addr - base;
	assign offset = rel_addr[12:0];

	assign vram_bus.cs = access && (region == gb_mem_pkg::REGION_VRAM);
	assign wram0_bus.cs = access && (region == gb_mem_pkg::REGION_WRAM0);
	assign wram1_bus.cs = access && (region == gb_mem_pkg::REGION_WRAM1);
	assign oam_bus.cs = access && (region == gb_mem_pkg::REGION_OAM);
	assign hram_bus.cs = access && (region == gb_mem_pkg::REGION_HRAM);
	assign io_bus.cs = access && (region == gb_mem_pkg::REGION_IO);

	// Shared fields go to every block, only cs differs
	assign vram_bus.we = wr;
	assign wram0_bus.we = wr;
	assign wram1_bus.we = wr;
	assign oam_bus.we = wr;
	assign hram_bus.we = wr;
	assign io_bus.we = wr;
	assign vram_bus.offset = offset;
	assign wram0_bus.offset = offset;
	assign wram1_bus.offset = offset;
	assign oam_bus.offset = offset;
	assign hram_bus.offset = offset;
	assign io_bus.offset = offset;
	assign vram_bus.wdata = wdata;
	assign wram0_bus.wdata = wdata;
	assign wram1_bus.wdata = wdata;
	assign oam_bus.wdata = wdata;
	assign hram_bus.wdata = wdata;
	assign io_bus.wdata = wdata;

	// Remember where the read went so the returning byte can be steered
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_valid <= 1'b0;
			rd_region <= gb_mem_pkg::REGION_NONE;
		end else begin
			rd_valid <= rd_only;
			if (rd_only) begin
				rd_region <= region;
			end
		end
	end

	always_comb begin
		case (rd_region)
			gb_mem_pkg::REGION_VRAM: rdata = vram_bus.rdata;
			gb_mem_pkg::REGION_WRAM0: rdata = wram0_bus.rdata;
			gb_mem_pkg::REGION_WRAM1: rdata = wram1_bus.rdata;
			gb_mem_pkg::REGION_OAM: rdata = oam_bus.rdata;
			gb_mem_pkg::REGION_IO: rdata = io_bus.rdata;
			gb_mem_pkg::REGION_HRAM: rdata = hram_bus.rdata;
			default: rdata = `GB_OPEN_BUS;
		endcase
	end

endmodule

// ==== design/gb_mem_pkg.sv ====
// Shared types for the memory unit; widths follow the 8-bit CPU with a 16-bit address bus
package gb_mem_pkg;

	// CPU address as seen on the bus
	typedef logic [15:0] addr_t;

	// One data byte
	typedef logic [7:0] byte_t;

	// Interrupt vector
	// bit 0 vblank, bit 1 stat, bit 2 timer, bit 3 serial, bit 4 joypad
	typedef logic [4:0] irq_t;

	// Region hit by an access, REGION_NONE covers every unmapped address
	typedef enum logic [2:0] {
		REGION_NONE,
		REGION_VRAM,
		REGION_WRAM0,
		REGION_WRAM1,
		REGION_OAM,
		REGION_IO,
		REGION_HRAM
	} region_t;

endpackage

// ==== design/gb_memory_unit.sv ====
// No cartridge ROM or MBC; no stalls, every read returns one cycle after its strobe
`include "gb_mem_cfg.svh"

module gb_memory_unit (
	input logic clk,
	input logic rst,
	// CPU side
	input gb_mem_pkg::addr_t addr,
	input gb_mem_pkg::byte_t wdata,
	input logic rd,
	input logic wr,
	output gb_mem_pkg::byte_t rdata,
	output logic rd_valid,
	// Peripheral side
	input logic [3:0] joy_keys,
	input gb_mem_pkg::byte_t ly,
	input logic [1:0] stat_mode,
	input gb_mem_pkg::byte_t div,
	input gb_mem_pkg::irq_t irq_req,
	output logic div_reset,
	output gb_mem_pkg::byte_t lcdc,
	output gb_mem_pkg::byte_t scy,
	output gb_mem_pkg::byte_t scx,
	output gb_mem_pkg::byte_t tma,
	output gb_mem_pkg::byte_t tac,
	output gb_mem_pkg::irq_t irq_pending
);

	mem_bus_if vram_bus ();
	mem_bus_if wram0_bus ();
	mem_bus_if wram1_bus ();
	mem_bus_if oam_bus ();
	mem_bus_if hram_bus ();
	mem_bus_if io_bus ();

	gb_mem_decoder decoder (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.wdata(wdata),
		.rd(rd),
		.wr(wr),
		.rdata(rdata),
		.rd_valid(rd_valid),
		.vram_bus(vram_bus.ctrl),
		.wram0_bus(wram0_bus.ctrl),
		.wram1_bus(wram1_bus.ctrl),
		.oam_bus(oam_bus.ctrl),
		.hram_bus(hram_bus.ctrl),
		.io_bus(io_bus.ctrl)
	);

	gb_ram_bank #(.DEPTH(`GB_VRAM_DEPTH)) vram (.clk(clk), .bus(vram_bus.bank));
	gb_ram_bank #(.DEPTH(`GB_WRAM_DEPTH)) wram0 (.clk(clk), .bus(wram0_bus.bank));
	gb_ram_bank #(.DEPTH(`GB_WRAM_DEPTH)) wram1 (.clk(clk), .bus(wram1_bus.bank));
	// Only the first 160 bytes are reachable through the decoder
	gb_ram_bank #(.DEPTH(`GB_OAM_DEPTH)) oam (.clk(clk), .bus(oam_bus.bank));
	gb_ram_bank #(.DEPTH(`GB_HRAM_DEPTH)) hram (.clk(clk), .bus(hram_bus.bank));

	gb_io_regs io_regs (
		.clk(clk),
		.rst(rst),
		.bus(io_bus.bank),
		.joy_keys(joy_keys),
		.ly(ly),
		.stat_mode(stat_mode),
		.div(div),
		.irq_req(irq_req),
		.div_reset(div_reset),
		.lcdc(lcdc),
		.scy(scy),
		.scx(scx),
		.tma(tma),
		.tac(tac),
		.irq_pending(irq_pending)
	);

endmodule

// ==== design/gb_ram_bank.sv ====
// DEPTH must be a power of two from 2 to 8192; contents power up undefined and are never cleared
module gb_ram_bank #(
	parameter int DEPTH = 8192
) (
	input logic clk,
	mem_bus_if.bank bus
);

	localparam int AW = $clog2(DEPTH);

	gb_mem_pkg::byte_t mem [DEPTH];
	logic [AW-1:0] index;

	// Upper offset bits are zero for every address the decoder maps here
	assign index = bus.offset[AW-1:0];

	always_ff @(posedge clk) begin
		if (bus.cs && bus.we) begin
			mem[index] <= bus.wdata;
		end
	end

	// Read port, rdata holds between reads
	always_ff @(posedge clk) begin
		if (bus.cs && !bus.we) begin
			bus.rdata <= mem[index];
		end
	end

endmodule

// ==== design/mem_bus_if.sv ====
// Decoder to block link; offset is 13 bits so no block may exceed 8 KiB
interface mem_bus_if;

	// One-cycle access strobe for this block only
	logic cs;
	logic we;
	// Address relative to the region base
	logic [12:0] offset;
	gb_mem_pkg::byte_t wdata;
	// Registered by the block, holds until its next read
	gb_mem_pkg::byte_t rdata;

	modport ctrl (
		output cs,
		output we,
		output offset,
		output wdata,
		input rdata
	);

	modport bank (
		input cs,
		input we,
		input offset,
		input wdata,
		output rdata
	);

endinterface

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module gb_memory_unit_tb -f build.f \
	-o gb_memory_unit_sim > sim.log 2>&1 &&
	./obj_dir/gb_memory_unit_sim >> sim.log 2>&1 ||
	echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// ==== tb/gb_memory_unit_chk.sv ====
// Samples on the rising edge; assumes DIV is never written in two consecutive cycles
module gb_memory_unit_chk (
	input logic clk,
	input logic rst,
	input gb_mem_pkg::addr_t addr,
	input logic rd,
	input logic wr,
	input logic rd_valid,
	input logic div_reset,
	input gb_mem_pkg::irq_t irq_pending
);
	timeunit 1ns;
	timeprecision 100ps;

	logic rd_only;
	logic div_write;

	assign rd_only = rd & ~wr;
	assign div_write = wr && (addr == 16'hFF04);

	read_gives_valid: assert property (@(posedge clk) disable iff (rst) rd_only |=> rd_valid)
		else $error("rd_valid missing one cycle after a read strobe");
	no_stray_valid: assert property (@(posedge clk) disable iff (rst) !rd_only |=> !rd_valid)
		else $error("rd_valid high without a read strobe");
	div_write_pulses: assert property (@(posedge clk) disable iff (rst) div_write |=> div_reset)
		else $error("div_reset missing after a DIV write");
	div_pulse_cause: assert property (@(posedge clk) disable iff (rst)
		div_reset |-> $past(div_write))
		else $error("div_reset without a DIV write");
	div_pulse_width: assert property (@(posedge clk) disable iff (rst) div_reset |=> !div_reset)
		else $error("div_reset longer than one cycle");
	quiet_in_reset: assert property (@(posedge clk) rst |-> (irq_pending == '0))
		else $error("irq_pending active during reset");

endmodule

bind gb_memory_unit gb_memory_unit_chk chk (
	.clk(clk),
	.rst(rst),
	.addr(addr),
	.rd(rd),
	.wr(wr),
	.rd_valid(rd_valid),
	.div_reset(div_reset),
	.irq_pending(irq_pending)
);

// ==== tb/gb_memory_unit_tb.sv ====
// Peripheral inputs are driven as static levels; no divider, LCD or cartridge model runs here
module gb_memory_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// Accesses per test: RAM edges, unmapped, I/O, peripheral, interrupt, random
	localparam int NUM_ACCESSES = 20 + 26 + 34 + 8 + 8 + 200;

	logic clk = 1'b0;
	logic rst, rd, wr, rd_valid, div_reset;
	logic [3:0] joy_keys;
	logic [1:0] stat_mode;
	gb_mem_pkg::addr_t addr;
	gb_mem_pkg::byte_t wdata, rdata, ly, div, lcdc, scy, scx, tma, tac;
	gb_mem_pkg::irq_t irq_req, irq_pending;
	// Expected RAM contents for the random traffic
	gb_mem_pkg::byte_t shadow [gb_mem_pkg::addr_t];
	gb_mem_pkg::addr_t written [$];

	gb_memory_unit UUT (.*);

	always #50 clk = ~clk;

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Every access starts and ends on a falling edge
	task automatic write_byte(input gb_mem_pkg::addr_t a, input gb_mem_pkg::byte_t d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		@(negedge clk);
		wr = 1'b0;
	endtask

	task automatic read_expect(input gb_mem_pkg::addr_t a, input gb_mem_pkg::byte_t exp);
		addr = a;
		rd = 1'b1;
		@(negedge clk);
		rd = 1'b0;
		check_value($sformatf("rd_valid at %04h", a), {7'b0, rd_valid}, 8'h01);
		check_value($sformatf("rdata at %04h", a), rdata, exp);
	endtask

	task automatic ram_edges();
		gb_mem_pkg::addr_t edges [10] = '{16'h8000, 16'h9FFF, 16'hA000, 16'hBFFF, 16'hC000,
			16'hDFFF, 16'hFE00, 16'hFE9F, 16'hFF80, 16'hFFFE};
		foreach (edges[i]) write_byte(edges[i], 8'(i * 17 + 15));
		foreach (edges[i]) read_expect(edges[i], 8'(i * 17 + 15));
	endtask

	task automatic unmapped_space();
		gb_mem_pkg::addr_t holes [7] = '{16'h0000, 16'h7FFF, 16'hE000, 16'hFDFF, 16'hFEA0,
			16'hFF4C, 16'hFF7F};
		gb_mem_pkg::addr_t near [6] = '{16'h8000, 16'hC000, 16'hDFFF, 16'hFE00, 16'hFE9F,
			16'hFF80};
		foreach (near[i]) write_byte(near[i], 8'(8'h3C + i));
		foreach (holes[i]) begin
			write_byte(holes[i], 8'h00);
			read_expect(holes[i], 8'hFF);
		end
		foreach (near[i]) read_expect(near[i], 8'(8'h3C + i));
	endtask

	task automatic io_plain_regs();
		logic [7:0] plain [14] = '{8'h01, 8'h02, 8'h06, 8'h40, 8'h42, 8'h43, 8'h45, 8'h46,
			8'h47, 8'h48, 8'h49, 8'h4A, 8'h4B, 8'hFF};
		foreach (plain[i]) write_byte({8'hFF, plain[i]}, plain[i] ^ 8'hA5);
		foreach (plain[i]) read_expect({8'hFF, plain[i]}, plain[i] ^ 8'hA5);
		write_byte(16'hFF07, 8'hFD);
		read_expect(16'hFF07, 8'h05);
		check_value("lcdc", lcdc, 8'hE5);
		check_value("scy", scy, 8'hE7);
		check_value("scx", scx, 8'hE6);
		check_value("tma", tma, 8'hA3);
		check_value("tac", tac, 8'h05);
		ly = 8'h33;
		write_byte(16'hFF44, 8'h77);
		read_expect(16'hFF44, 8'h33);
		write_byte(16'hFF03, 8'h12);
		read_expect(16'hFF03, 8'hFF);
	endtask

	task automatic peripheral_fields();
		joy_keys = 4'hA;
		write_byte(16'hFF00, 8'h20);
		read_expect(16'hFF00, 8'hEA);
		// Coincidence set, then cleared by moving the line counter
		ly = 8'h20;
		stat_mode = 2'b10;
		write_byte(16'hFF45, 8'h20);
		write_byte(16'hFF41, 8'hFF);
		read_expect(16'hFF41, 8'hFE);
		ly = 8'h21;
		stat_mode = 2'b01;
		@(negedge clk);
		read_expect(16'hFF41, 8'hF9);
		div = 8'h9C;
		@(negedge clk);
		read_expect(16'hFF04, 8'h9C);
		write_byte(16'hFF04, 8'h00);
		check_value("div_reset pulse", {7'b0, div_reset}, 8'h01);
		@(negedge clk);
		check_value("div_reset end", {7'b0, div_reset}, 8'h00);
	endtask

	task automatic interrupt_flags();
		write_byte(16'hFFFF, 8'h05);
		write_byte(16'hFF0F, 8'h00);
		irq_req = 5'b00111;
		@(negedge clk);
		irq_req = 5'b00000;
		read_expect(16'hFF0F, 8'hE7);
		check_value("irq_pending", {3'b0, irq_pending}, 8'h05);
		write_byte(16'hFF0F, 8'h00);
		read_expect(16'hFF0F, 8'hE0);
		check_value("irq_pending after clear", {3'b0, irq_pending}, 8'h00);
		// Joypad request lands in the same cycle as the clearing write
		irq_req = 5'b10000;
		write_byte(16'hFF0F, 8'h00);
		irq_req = 5'b00000;
		read_expect(16'hFF0F, 8'hF0);
		write_byte(16'hFFFF, 8'h1F);
		check_value("irq_pending joypad", {3'b0, irq_pending}, 8'h10);
	endtask

	function automatic gb_mem_pkg::addr_t random_ram_addr();
		logic [15:0] off;
		off = 16'($urandom);
		case ($urandom_range(4, 0))
			0: return 16'h8000 + {3'b0, off[12:0]};
			1: return 16'hA000 + {3'b0, off[12:0]};
			2: return 16'hC000 + {3'b0, off[12:0]};
			3: return 16'hFE00 + 16'(off % 160);
			default: return 16'hFF80 + 16'(off % 127);
		endcase
	endfunction

	task automatic random_traffic();
		gb_mem_pkg::addr_t a;
		gb_mem_pkg::byte_t d;
		repeat (200) begin
			if (written.size() == 0 || $urandom_range(1, 0) == 0) begin
				a = random_ram_addr();
				d = 8'($urandom);
				write_byte(a, d);
				if (!shadow.exists(a)) begin
					written.push_back(a);
				end
				shadow[a] = d;
			end else begin
				a = written[$urandom_range(written.size() - 1, 0)];
				read_expect(a, shadow[a]);
			end
		end
	endtask

	initial begin
		#((NUM_ACCESSES + 200) * 100);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(94));
		rst = 1'b1;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		joy_keys = '0;
		ly = '0;
		stat_mode = '0;
		div = '0;
		irq_req = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		check_value("reset state", {5'b0, rd_valid, div_reset, |irq_pending}, 8'h00);
		ram_edges();
		unmapped_space();
		io_plain_regs();
		peripheral_fields();
		interrupt_flags();
		random_traffic();
		$display("Result: PASSED");
		$finish;
	end

endmodule
